//--- Makefile
TOOL       = verilator
FLAGS      = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing
TOP        = tb_lsu_top
FILELIST   = sources.f
BUILD      = obj_dir
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- design/lsu_defs.svh
// load/store unit parameters

`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// data path and bus widths
`define LSU_XLEN        32
`define LSU_STRB_W      4
`define LSU_REG_ADDR_W  5
`define LSU_COMMIT_ID_W 3

// entries in the tag queue and the write-data queue
`define LSU_FIFO_DEPTH  4

// bit positions inside the one-hot load kind
`define LSU_LD_LB       0
`define LSU_LD_LH       1
`define LSU_LD_LW       2
`define LSU_LD_LBU      3
`define LSU_LD_LHU      4

// bit positions inside the one-hot store kind
`define LSU_ST_SB       0
`define LSU_ST_SH       1
`define LSU_ST_SW       2

`endif

//--- design/lsu_fifo.sv
// synchronous queue

`timescale 1ns/10ps

`include "lsu_defs.svh"

module lsu_fifo #(
    parameter int WIDTH = 36
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push_i,
    input  logic             pop_i,
    input  logic [WIDTH-1:0] din_i,
    output logic [WIDTH-1:0] dout_o,
    output logic             empty_o,
    output logic             full_o
);

    localparam int DEPTH = `LSU_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    logic [WIDTH-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr_nxt;
    logic [PTR_W-1:0] rd_ptr_nxt;
    logic             do_push;
    logic             do_pop;
    logic             empty_q;
    logic             full_q;

    // a push into a full queue only lands when the head leaves in the same cycle
    assign do_push = push_i & (~full_q | pop_i);
    assign do_pop  = pop_i & ~empty_q;

    assign wr_ptr_nxt = (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
    assign rd_ptr_nxt = (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            empty_q <= 1'b1;
            full_q  <= 1'b0;
        end else if (do_push || do_pop) begin
            if (do_push) begin
                wr_ptr <= wr_ptr_nxt;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr_nxt;
            end
            // flags only move when the fill level changes
            if (do_push && !do_pop) begin
                empty_q <= 1'b0;
                full_q  <= (wr_ptr_nxt == rd_ptr);
            end else if (do_pop && !do_push) begin
                full_q  <= 1'b0;
                empty_q <= (rd_ptr_nxt == wr_ptr);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[wr_ptr] <= din_i;
        end
    end

    // head is visible without waiting for a pop
    assign dout_o  = mem_q[rd_ptr];
    assign empty_o = empty_q;
    assign full_o  = full_q;

endmodule

//--- design/lsu_load_align.sv
// load data extraction

`timescale 1ns/10ps

`include "lsu_defs.svh"

module lsu_load_align import lsu_pkg::*; (
    input  byte_off_t offset_i,
    input  ld_kind_t  ld_kind_i,
    input  data_t     rdata_i,
    output data_t     result_o
);

    data_t       shifted;
    logic [7:0]  lane_byte;
    logic [15:0] lane_half;

    // move the addressed byte down to bit 0
    assign shifted   = rdata_i >> {offset_i, 3'b000};
    assign lane_byte = shifted[7:0];
    assign lane_half = offset_i[1] ? rdata_i[31:16] : rdata_i[15:0];

    always_comb begin
        result_o = '0;
        if (ld_kind_i[`LSU_LD_LB]) begin
            result_o = {{24{lane_byte[7]}}, lane_byte};
        end else if (ld_kind_i[`LSU_LD_LH]) begin
            result_o = {{16{lane_half[15]}}, lane_half};
        end else if (ld_kind_i[`LSU_LD_LW]) begin
            result_o = rdata_i;
        end else if (ld_kind_i[`LSU_LD_LBU]) begin
            result_o = {24'h0, lane_byte};
        end else if (ld_kind_i[`LSU_LD_LHU]) begin
            result_o = {16'h0, lane_half};
        end
    end

endmodule

//--- design/lsu_pkg.sv
// load/store unit types

`include "lsu_defs.svh"

package lsu_pkg;

    // byte address and data word
    typedef logic [`LSU_XLEN-1:0] addr_t;
    typedef logic [`LSU_XLEN-1:0] data_t;

    // one enable bit per byte lane
    typedef logic [`LSU_STRB_W-1:0] strb_t;

    // lane index, address bits 1..0
    typedef logic [$clog2(`LSU_STRB_W)-1:0] byte_off_t;

    // writeback tags
    typedef logic [`LSU_REG_ADDR_W-1:0]  reg_addr_t;
    typedef logic [`LSU_COMMIT_ID_W-1:0] commit_id_t;

    // one-hot op kinds
    typedef logic [`LSU_LD_LHU:0] ld_kind_t;
    typedef logic [`LSU_ST_SW:0]  st_kind_t;

endpackage

//--- design/lsu_read_ctrl.sv
// load path

`timescale 1ns/10ps

module lsu_read_ctrl import lsu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       load_valid_i,
    input  addr_t      addr_i,
    input  ld_kind_t   ld_kind_i,
    input  reg_addr_t  rd_addr_i,
    input  commit_id_t commit_id_i,
    input  logic       arready_i,
    input  logic       rvalid_i,
    input  data_t      rdata_i,
    output logic       arvalid_o,
    output addr_t      araddr_o,
    output logic       rready_o,
    output logic       load_stall_o,
    output logic       reg_we_o,
    output data_t      reg_wdata_o,
    output reg_addr_t  reg_waddr_o,
    output commit_id_t commit_id_o
);

    // kind, lane, rd and commit id of one outstanding read
    localparam int TAG_W = $bits(ld_kind_t) + $bits(byte_off_t) + $bits(reg_addr_t)
                         + $bits(commit_id_t);

    logic             ar_fire;
    logic             bypass;
    logic             rsp_valid;
    logic             tag_push;
    logic             tag_pop;
    logic             tag_empty;
    logic             tag_full;
    logic [TAG_W-1:0] tag_in;
    logic [TAG_W-1:0] tag_head;
    logic [TAG_W-1:0] tag_cur;
    byte_off_t        req_off;
    ld_kind_t         cur_kind;
    byte_off_t        cur_off;
    reg_addr_t        cur_rd;
    commit_id_t       cur_cid;
    data_t            load_data;

    // no new read goes out while every tag slot is taken
    assign arvalid_o    = load_valid_i & ~tag_full;
    assign araddr_o     = addr_i;
    assign rready_o     = 1'b1;
    assign load_stall_o = load_valid_i & (tag_full | ~arready_i);

    assign ar_fire = arvalid_o & arready_i;
    assign req_off = addr_i[1:0];
    assign tag_in  = {ld_kind_i, req_off, rd_addr_i, commit_id_i};

    // response in the very cycle of the request, nothing older pending
    assign bypass    = tag_empty & ar_fire & rvalid_i;
    assign tag_push  = ar_fire & ~bypass;
    assign tag_pop   = rvalid_i & ~tag_empty;
    assign rsp_valid = tag_pop | bypass;

    lsu_fifo #(
        .WIDTH (TAG_W)
    ) i_tag_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push_i  (tag_push),
        .pop_i   (tag_pop),
        .din_i   (tag_in),
        .dout_o  (tag_head),
        .empty_o (tag_empty),
        .full_o  (tag_full)
    );

    assign tag_cur = bypass ? tag_in : tag_head;
    assign {cur_kind, cur_off, cur_rd, cur_cid} = tag_cur;

    lsu_load_align i_load_align (
        .offset_i  (cur_off),
        .ld_kind_i (cur_kind),
        .rdata_i   (rdata_i),
        .result_o  (load_data)
    );

    // writeback one cycle after the response, held until the next one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_we_o    <= 1'b0;
            reg_wdata_o <= '0;
            reg_waddr_o <= '0;
            commit_id_o <= '0;
        end else begin
            reg_we_o <= rsp_valid;
            if (rsp_valid) begin
                reg_wdata_o <= load_data;
                reg_waddr_o <= cur_rd;
                commit_id_o <= cur_cid;
            end
        end
    end

endmodule

//--- design/lsu_store_align.sv
// store data alignment

`timescale 1ns/10ps

`include "lsu_defs.svh"

module lsu_store_align import lsu_pkg::*; (
    input  byte_off_t offset_i,
    input  st_kind_t  st_kind_i,
    input  data_t     data_i,
    output data_t     wdata_o,
    output strb_t     wstrb_o
);

    logic [4:0] byte_shift;
    logic [4:0] half_shift;

    // bit shift for the addressed byte lane and half-word lane
    assign byte_shift = {offset_i, 3'b000};
    assign half_shift = {offset_i[1], 4'b0000};

    always_comb begin
        wdata_o = '0;
        wstrb_o = '0;
        if (st_kind_i[`LSU_ST_SB]) begin
            wdata_o = data_t'(data_i[7:0]) << byte_shift;
            wstrb_o = strb_t'(4'b0001) << offset_i;
        end else if (st_kind_i[`LSU_ST_SH]) begin
            wdata_o = data_t'(data_i[15:0]) << half_shift;
            // low pair or high pair of lanes
            wstrb_o = offset_i[1] ? strb_t'(4'b1100) : strb_t'(4'b0011);
        end else if (st_kind_i[`LSU_ST_SW]) begin
            wdata_o = data_i;
            wstrb_o = '1;
        end
    end

endmodule

//--- design/lsu_top.sv
// load/store unit

`timescale 1ns/10ps

module lsu_top import lsu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    // core request
    input  logic       req_mem_i,
    input  addr_t      mem_op1_i,
    input  addr_t      mem_op2_i,
    input  data_t      mem_rs2_data_i,
    input  ld_kind_t   ld_kind_i,
    input  st_kind_t   st_kind_i,
    input  reg_addr_t  rd_addr_i,
    input  commit_id_t commit_id_i,
    input  logic       int_assert_i,
    // bus inputs
    input  logic       arready_i,
    input  logic       rvalid_i,
    input  data_t      rdata_i,
    input  logic       awready_i,
    input  logic       wready_i,
    input  logic       bvalid_i,
    // core status and writeback
    output logic       mem_stall_o,
    output logic       mem_busy_o,
    output logic       reg_we_o,
    output data_t      reg_wdata_o,
    output reg_addr_t  reg_waddr_o,
    output commit_id_t commit_id_o,
    // bus outputs
    output logic       arvalid_o,
    output addr_t      araddr_o,
    output logic       rready_o,
    output logic       awvalid_o,
    output addr_t      awaddr_o,
    output logic       wvalid_o,
    output data_t      wdata_o,
    output strb_t      wstrb_o,
    output logic       bready_o
);

    addr_t eff_addr;
    logic  req_valid;
    logic  load_valid;
    logic  store_valid;
    logic  load_stall;
    logic  store_stall;

    assign eff_addr = mem_op1_i + mem_op2_i;

    // an interrupt holds back any new request
    assign req_valid   = req_mem_i & ~int_assert_i;
    assign load_valid  = req_valid & (|ld_kind_i);
    assign store_valid = req_valid & (|st_kind_i);

    assign mem_stall_o = load_stall | store_stall;

    lsu_read_ctrl i_read_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_valid_i (load_valid),
        .addr_i       (eff_addr),
        .ld_kind_i    (ld_kind_i),
        .rd_addr_i    (rd_addr_i),
        .commit_id_i  (commit_id_i),
        .arready_i    (arready_i),
        .rvalid_i     (rvalid_i),
        .rdata_i      (rdata_i),
        .arvalid_o    (arvalid_o),
        .araddr_o     (araddr_o),
        .rready_o     (rready_o),
        .load_stall_o (load_stall),
        .reg_we_o     (reg_we_o),
        .reg_wdata_o  (reg_wdata_o),
        .reg_waddr_o  (reg_waddr_o),
        .commit_id_o  (commit_id_o)
    );

    // bvalid_i is accepted by the always-high bready and dropped
    lsu_write_ctrl i_write_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .store_valid_i (store_valid),
        .addr_i        (eff_addr),
        .st_kind_i     (st_kind_i),
        .store_data_i  (mem_rs2_data_i),
        .awready_i     (awready_i),
        .wready_i      (wready_i),
        .awvalid_o     (awvalid_o),
        .awaddr_o      (awaddr_o),
        .wvalid_o      (wvalid_o),
        .wdata_o       (wdata_o),
        .wstrb_o       (wstrb_o),
        .bready_o      (bready_o),
        .store_stall_o (store_stall),
        .busy_o        (mem_busy_o)
    );

endmodule

//--- design/lsu_write_ctrl.sv
// store path

`timescale 1ns/10ps

module lsu_write_ctrl import lsu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     store_valid_i,
    input  addr_t    addr_i,
    input  st_kind_t st_kind_i,
    input  data_t    store_data_i,
    input  logic     awready_i,
    input  logic     wready_i,
    output logic     awvalid_o,
    output addr_t    awaddr_o,
    output logic     wvalid_o,
    output data_t    wdata_o,
    output strb_t    wstrb_o,
    output logic     bready_o,
    output logic     store_stall_o,
    output logic     busy_o
);

    localparam int WQ_W = $bits(strb_t) + $bits(data_t);

    logic            aw_fire;
    logic            wq_push;
    logic            wq_pop;
    logic            wq_empty;
    logic            wq_full;
    byte_off_t       st_off;
    data_t           new_wdata;
    strb_t           new_wstrb;
    data_t           head_wdata;
    strb_t           head_wstrb;
    logic [WQ_W-1:0] wq_head;

    assign st_off = addr_i[1:0];

    lsu_store_align i_store_align (
        .offset_i  (st_off),
        .st_kind_i (st_kind_i),
        .data_i    (store_data_i),
        .wdata_o   (new_wdata),
        .wstrb_o   (new_wstrb)
    );

    // address goes out only if its data beat has a place to wait
    assign awvalid_o     = store_valid_i & ~wq_full;
    assign awaddr_o      = addr_i;
    assign aw_fire       = awvalid_o & awready_i;
    assign store_stall_o = store_valid_i & (wq_full | ~awready_i);

    // older beats first, new data only bypasses an empty queue
    assign wq_push = aw_fire & ~(wq_empty & wready_i);
    assign wq_pop  = ~wq_empty & wready_i;

    lsu_fifo #(
        .WIDTH (WQ_W)
    ) i_wdata_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push_i  (wq_push),
        .pop_i   (wq_pop),
        .din_i   ({new_wstrb, new_wdata}),
        .dout_o  (wq_head),
        .empty_o (wq_empty),
        .full_o  (wq_full)
    );

    assign {head_wstrb, head_wdata} = wq_head;

    assign wvalid_o = ~wq_empty | aw_fire;
    assign wdata_o  = wq_empty ? new_wdata : head_wdata;
    assign wstrb_o  = wq_empty ? new_wstrb : head_wstrb;

    // write responses carry nothing the core needs
    assign bready_o = 1'b1;
    assign busy_o   = ~wq_empty;

endmodule

//--- sources.f
+incdir+design
design/lsu_pkg.sv
design/lsu_fifo.sv
design/lsu_store_align.sv
design/lsu_load_align.sv
design/lsu_read_ctrl.sv
design/lsu_write_ctrl.sv
design/lsu_top.sv
test/tb_lsu_top.sv

//--- test/tb_lsu_top.sv
// load/store unit testbench

`timescale 1ns/10ps

`include "lsu_defs.svh"

module tb_lsu_top import lsu_pkg::*; ();

    // well above the few hundred cycles that all tests take together
    localparam int MAX_CYCLES = 4000;

    logic       clk;
    logic       rst_n;
    logic       req_mem_i;
    addr_t      mem_op1_i;
    addr_t      mem_op2_i;
    data_t      mem_rs2_data_i;
    ld_kind_t   ld_kind_i;
    st_kind_t   st_kind_i;
    reg_addr_t  rd_addr_i;
    commit_id_t commit_id_i;
    logic       int_assert_i;
    logic       arready_i;
    logic       rvalid_i;
    data_t      rdata_i;
    logic       awready_i;
    logic       wready_i;
    logic       bvalid_i;
    logic       mem_stall_o;
    logic       mem_busy_o;
    logic       reg_we_o;
    data_t      reg_wdata_o;
    reg_addr_t  reg_waddr_o;
    commit_id_t commit_id_o;
    logic       arvalid_o;
    addr_t      araddr_o;
    logic       rready_o;
    logic       awvalid_o;
    addr_t      awaddr_o;
    logic       wvalid_o;
    data_t      wdata_o;
    strb_t      wstrb_o;
    logic       bready_o;

    // responder state
    data_t      mem [16];
    logic       same_cycle = 1'b0;
    int         rd_delay = 1;
    logic       rvalid_dly = 1'b0;
    data_t      rdata_dly = '0;
    addr_t      rd_addr_q [$];
    int         rd_due_q [$];
    addr_t      aw_q [$];
    data_t      w_data_log [$];
    strb_t      w_strb_log [$];

    // writebacks seen on the register port
    data_t      wb_data [$];
    reg_addr_t  wb_rd [$];
    commit_id_t wb_cid [$];

    int         cycle = 0;
    int         checks = 0;
    int         errors = 0;
    integer     seed = 32'hd74b_30f1;

    lsu_top i_lsu_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (cycle >= MAX_CYCLES) begin
            $display("timeout: run did not complete within %0d cycles", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end else begin
            cycle <= cycle + 1;
        end
    end

    // zero-latency reply when same_cycle is set
    assign rvalid_i = same_cycle ? (arvalid_o & arready_i) : rvalid_dly;
    assign rdata_i  = same_cycle ? mem[araddr_o[5:2]] : rdata_dly;

    // bus handshakes as the DUT sees them at the edge
    always @(posedge clk) begin
        addr_t a;
        data_t m;
        if (arvalid_o && arready_i && !same_cycle) begin
            rd_addr_q.push_back(araddr_o);
            rd_due_q.push_back(cycle + rd_delay);
        end
        if (awvalid_o && awready_i) begin
            aw_q.push_back(awaddr_o);
        end
        if (wvalid_o && wready_i && aw_q.size() != 0) begin
            a = aw_q.pop_front();
            m = byte_mask(wstrb_o);
            mem[a[5:2]] = (mem[a[5:2]] & ~m) | (wdata_o & m);
            w_data_log.push_back(wdata_o);
            w_strb_log.push_back(wstrb_o);
        end
        if (reg_we_o) begin
            wb_data.push_back(reg_wdata_o);
            wb_rd.push_back(reg_waddr_o);
            wb_cid.push_back(commit_id_o);
        end
    end

    // delayed read responses, oldest first
    always @(negedge clk) begin
        addr_t a;
        rvalid_dly = 1'b0;
        if (rd_addr_q.size() != 0 && cycle >= rd_due_q[0]) begin
            a = rd_addr_q.pop_front();
            void'(rd_due_q.pop_front());
            rvalid_dly = 1'b1;
            rdata_dly  = mem[a[5:2]];
        end
    end

    function automatic data_t byte_mask(strb_t s);
        data_t m;
        for (int i = 0; i < 4; i++) begin
            m[8*i +: 8] = {8{s[i]}};
        end
        return m;
    endfunction

    function automatic data_t expect_load(data_t word, int off, int kind);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = word[16*(off/2) +: 16];
        case (kind)
            `LSU_LD_LB:  return {{24{b[7]}}, b};
            `LSU_LD_LH:  return {{16{h[15]}}, h};
            `LSU_LD_LW:  return word;
            `LSU_LD_LBU: return {24'h0, b};
            `LSU_LD_LHU: return {16'h0, h};
            default:     return '0;
        endcase
    endfunction

    function automatic strb_t expect_strb(int kind, int off);
        case (kind)
            `LSU_ST_SB: return strb_t'(1 << off);
            `LSU_ST_SH: return (off >= 2) ? 4'b1100 : 4'b0011;
            default:    return 4'b1111;
        endcase
    endfunction

    // low byte or half repeated, the strobe picks the lane
    function automatic data_t expect_lanes(int kind, data_t d);
        case (kind)
            `LSU_ST_SB: return {4{d[7:0]}};
            `LSU_ST_SH: return {2{d[15:0]}};
            default:    return d;
        endcase
    endfunction

    function automatic addr_t word_addr(int w);
        return 32'h8000_0000 | addr_t'(w << 2);
    endfunction

    task automatic check_data(string name, data_t exp, data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_strb(string name, strb_t exp, strb_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_reg(string name, reg_addr_t exp, reg_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_cid(string name, commit_id_t exp, commit_id_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic report_failure(string msg);
        checks++;
        errors++;
        $display("%s", msg);
    endtask

    task automatic end_test(string name, int start_errors);
        $display("test %s finished with %0d errors", name, errors - start_errors);
    endtask

    // operands straddle the target so the adder carries
    task automatic drive_load(addr_t base, int off, ld_kind_t kind, reg_addr_t rd,
                              commit_id_t cid);
        req_mem_i   = 1'b1;
        mem_op1_i   = base + 32'h40;
        mem_op2_i   = addr_t'(off) - 32'h40;
        ld_kind_i   = kind;
        st_kind_i   = '0;
        rd_addr_i   = rd;
        commit_id_i = cid;
    endtask

    task automatic drive_store(addr_t base, int off, st_kind_t kind, data_t d);
        req_mem_i      = 1'b1;
        mem_op1_i      = base;
        mem_op2_i      = addr_t'(off);
        ld_kind_i      = '0;
        st_kind_i      = kind;
        mem_rs2_data_i = d;
    endtask

    task automatic drive_idle();
        req_mem_i = 1'b0;
        ld_kind_i = '0;
        st_kind_i = '0;
    endtask

    task automatic test_reset();
        int start;
        start = errors;
        check_flag("reset", 1'b0, reg_we_o);
        check_flag("reset", 1'b0, arvalid_o);
        check_flag("reset", 1'b0, awvalid_o);
        check_flag("reset", 1'b0, wvalid_o);
        check_flag("reset", 1'b0, mem_stall_o);
        check_flag("reset", 1'b0, mem_busy_o);
        // both response channels are always accepted
        check_flag("reset", 1'b1, rready_o);
        check_flag("reset", 1'b1, bready_o);
        check_data("reset", '0, reg_wdata_o);
        check_reg("reset", '0, reg_waddr_o);
        check_cid("reset", '0, commit_id_o);
        end_test("reset", start);
    endtask

    // every kind at every lane, answered in the request cycle
    task automatic test_load_lanes();
        int         start;
        int         w;
        data_t      exp;
        reg_addr_t  rd;
        commit_id_t cid;
        start = errors;
        same_cycle = 1'b1;
        for (int k = 0; k < 5; k++) begin
            for (int o = 0; o < 4; o++) begin
                w   = (k * 4 + o) % 16;
                rd  = reg_addr_t'($random(seed));
                cid = commit_id_t'($random(seed));
                exp = expect_load(mem[w], o, k);
                @(negedge clk);
                drive_load(word_addr(w), o, ld_kind_t'(1 << k), rd, cid);
                check_flag("load_lanes", 1'b0, reg_we_o);
                @(negedge clk);
                check_data("load_lanes", word_addr(w) + addr_t'(o), araddr_o);
                drive_idle();
                check_flag("load_lanes", 1'b1, reg_we_o);
                check_data("load_lanes", exp, reg_wdata_o);
                check_reg("load_lanes", rd, reg_waddr_o);
                check_cid("load_lanes", cid, commit_id_o);
                @(negedge clk);
                check_flag("load_lanes", 1'b0, reg_we_o);
            end
        end
        same_cycle = 1'b0;
        end_test("load_lanes", start);
    endtask

    task automatic test_outstanding();
        int start;
        start = errors;
        rd_delay = 6;
        wb_data.delete();
        wb_rd.delete();
        wb_cid.delete();
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            drive_load(word_addr(i + 4), 0, ld_kind_t'(1 << `LSU_LD_LW), reg_addr_t'(i + 3),
                       commit_id_t'(i));
        end
        // four tags in flight, the fifth load waits for a free slot
        @(negedge clk);
        check_flag("outstanding", 1'b1, mem_stall_o);
        while (mem_stall_o) @(negedge clk);
        @(negedge clk);
        drive_idle();
        while (wb_data.size() < 5) @(negedge clk);
        for (int i = 0; i < 5; i++) begin
            check_data("outstanding", mem[i + 4], wb_data[i]);
            check_reg("outstanding", reg_addr_t'(i + 3), wb_rd[i]);
            check_cid("outstanding", commit_id_t'(i), wb_cid[i]);
        end
        end_test("outstanding", start);
    endtask

    task automatic test_store_lanes();
        int    start;
        data_t d;
        data_t shadow;
        data_t mask;
        data_t lanes;
        strb_t strb;
        start = errors;
        w_data_log.delete();
        w_strb_log.delete();
        shadow = mem[9];
        for (int s = 0; s < 3; s++) begin
            for (int o = 0; o < 4; o++) begin
                d     = $random(seed);
                strb  = expect_strb(s, o);
                mask  = byte_mask(strb);
                lanes = expect_lanes(s, d);
                @(negedge clk);
                drive_store(word_addr(9), o, st_kind_t'(1 << s), d);
                @(negedge clk);
                check_data("store_lanes", word_addr(9) + addr_t'(o), awaddr_o);
                drive_idle();
                while (w_strb_log.size() == 0) @(negedge clk);
                check_strb("store_lanes", strb, w_strb_log.pop_front());
                check_data("store_lanes", lanes & mask, w_data_log.pop_front() & mask);
                shadow = (shadow & ~mask) | (lanes & mask);
            end
        end
        check_data("store_lanes", shadow, mem[9]);
        end_test("store_lanes", start);
    endtask

    task automatic test_store_queue();
        int    start;
        data_t exp_d [5];
        start = errors;
        w_data_log.delete();
        w_strb_log.delete();
        for (int i = 0; i < 5; i++) begin
            exp_d[i] = $random(seed);
        end
        @(negedge clk);
        wready_i = 1'b0;
        for (int i = 0; i < 4; i++) begin
            drive_store(word_addr(11 + i), 0, st_kind_t'(1 << `LSU_ST_SW), exp_d[i]);
            @(negedge clk);
        end
        // write queue full, data channel blocked
        drive_store(word_addr(15), 0, st_kind_t'(1 << `LSU_ST_SW), exp_d[4]);
        @(negedge clk);
        check_flag("store_queue", 1'b1, mem_busy_o);
        check_flag("store_queue", 1'b1, wvalid_o);
        check_flag("store_queue", 1'b1, mem_stall_o);
        @(negedge clk);
        check_flag("store_queue", 1'b1, mem_stall_o);
        wready_i = 1'b1;
        while (mem_stall_o) @(negedge clk);
        @(negedge clk);
        drive_idle();
        while (w_data_log.size() < 5) @(negedge clk);
        check_flag("store_queue", 1'b0, mem_busy_o);
        for (int i = 0; i < 5; i++) begin
            check_data("store_queue", exp_d[i], w_data_log[i]);
            check_strb("store_queue", 4'hf, w_strb_log[i]);
            check_data("store_queue", exp_d[i], mem[11 + i]);
        end
        end_test("store_queue", start);
    endtask

    task automatic test_int_gate();
        int start;
        start = errors;
        rd_delay = 2;
        wb_data.delete();
        wb_rd.delete();
        wb_cid.delete();
        w_data_log.delete();
        w_strb_log.delete();
        @(negedge clk);
        int_assert_i = 1'b1;
        drive_load(word_addr(2), 0, ld_kind_t'(1 << `LSU_LD_LW), 5'd7, 3'd5);
        repeat (2) begin
            @(negedge clk);
            check_flag("int_gate", 1'b0, arvalid_o);
            check_flag("int_gate", 1'b0, mem_stall_o);
        end
        drive_store(word_addr(3), 0, st_kind_t'(1 << `LSU_ST_SW), $random(seed));
        repeat (2) begin
            @(negedge clk);
            check_flag("int_gate", 1'b0, awvalid_o);
            check_flag("int_gate", 1'b0, wvalid_o);
        end
        // interrupt gone, read address channel not ready
        drive_load(word_addr(2), 0, ld_kind_t'(1 << `LSU_LD_LW), 5'd7, 3'd5);
        int_assert_i = 1'b0;
        arready_i    = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_flag("int_gate", 1'b1, mem_stall_o);
            check_flag("int_gate", 1'b1, arvalid_o);
        end
        arready_i = 1'b1;
        @(negedge clk);
        drive_idle();
        while (wb_data.size() == 0) @(negedge clk);
        repeat (4) @(negedge clk);
        if (wb_data.size() != 1 || w_data_log.size() != 0) begin
            report_failure("int_gate: a request held during the interrupt reached the bus");
        end
        check_data("int_gate", mem[2], wb_data[0]);
        check_reg("int_gate", 5'd7, wb_rd[0]);
        check_cid("int_gate", 3'd5, wb_cid[0]);
        end_test("int_gate", start);
    endtask

    initial begin
        rst_n          = 1'b0;
        req_mem_i      = 1'b0;
        mem_op1_i      = '0;
        mem_op2_i      = '0;
        mem_rs2_data_i = '0;
        ld_kind_i      = '0;
        st_kind_i      = '0;
        rd_addr_i      = '0;
        commit_id_i    = '0;
        int_assert_i   = 1'b0;
        arready_i      = 1'b1;
        awready_i      = 1'b1;
        wready_i       = 1'b1;
        bvalid_i       = 1'b0;
        for (int i = 0; i < 16; i++) begin
            mem[i] = $random(seed);
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset();
        test_load_lanes();
        test_outstanding();
        test_store_lanes();
        test_store_queue();
        test_int_gate();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
